//--- hdl/soc_periph_pkg.sv
// SoC peripheral buffer package
// Buffer sizing, entry types and interrupt flag vectors
`default_nettype none

package soc_periph_pkg;

  // ========================================
  // UART buffer sizing
  // ========================================

  // Entries per buffer, same as the two small UART RAMs
  localparam int unsigned BUF_DEPTH  = 16;
  localparam int unsigned BUF_ADDR_W = 4;

  // Counts 0 to BUF_DEPTH inclusive
  localparam int unsigned CREDIT_W   = 5;

  // ========================================
  // Buffer entry types
  // ========================================

  typedef logic [7:0]            uart_byte_t;

  // [7:0] data, [8] parity error, [9] framing error
  typedef logic [9:0]            uart_rx_entry_t;

  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
  typedef logic [CREDIT_W-1:0]   credit_t;

  // ========================================
  // Interrupt source vectors
  // ========================================

  // One bit per I2C condition, msb first:
  // activity, gen_call, rd_req, rx_done, rx_full, rx_over,
  // rx_under, scl_stuck_at_low, smbus_clk_mext, smbus_clk_sext,
  // smbus_host_notify, smbus_quick_cmd_det, start_det, stop_det,
  // tx_abrt, tx_empty, tx_over
  typedef logic [16:0]           i2c_irq_t;

  // mst, rxf, rxo, rxu, txe, txo
  typedef logic [5:0]            spi_irq_t;

  // One per timer
  typedef logic [1:0]            timer_irq_t;

endpackage

`default_nettype wire

//--- hdl/periph_buffer_ram.sv
// Small UART buffer RAM
// One write port, one read port with a registered output
`timescale 1ns/1ns
`default_nettype none

module periph_buffer_ram #(
  parameter int unsigned WIDTH = 8
) (
  input  wire                        i_periph_clk,
  input  wire                        i_periph_rst_n,
  input  wire logic                  i_wr_en,
  input  wire soc_periph_pkg::buf_addr_t i_wr_addr,
  input  wire logic [WIDTH-1:0]      i_wr_data,
  input  wire logic                  i_rd_en,
  input  wire soc_periph_pkg::buf_addr_t i_rd_addr,
  output logic [WIDTH-1:0]           o_rd_data
);
  import soc_periph_pkg::*;

  logic [WIDTH-1:0] mem [BUF_DEPTH];

  // Write port
  always_ff @(posedge i_periph_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge i_periph_clk or negedge i_periph_rst_n) begin
    if (!i_periph_rst_n) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hdl/credit_fifo.sv
// Credit-controlled UART buffer
// Writer spends credits on pushes, reader grants credits to pull entries
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
  parameter int unsigned WIDTH = 8
) (
  input  wire                     i_periph_clk,
  input  wire                     i_periph_rst_n,
  // Write side
  input  wire logic               i_push,
  input  wire logic [WIDTH-1:0]   i_push_data,
  output logic                    o_push_credit,
  // Read side
  input  wire logic               i_out_credit,
  output logic                    o_out_valid,
  output logic [WIDTH-1:0]        o_out_data,
  // Entries held
  output soc_periph_pkg::credit_t o_level
);
  import soc_periph_pkg::*;

  buf_addr_t        wr_ptr;
  buf_addr_t        rd_ptr;
  credit_t          level_q;
  credit_t          level_d;
  credit_t          out_credit_q;
  credit_t          out_credit_d;
  logic             credit_take;
  logic             rd_launch;
  logic             valid_q;
  logic [WIDTH-1:0] rd_data;

  // ========================================
  // Launch and counter updates
  // ========================================

  // Needs an entry and a reader credit
  assign rd_launch = (level_q != '0) && (out_credit_q != '0);

  // Grants beyond BUF_DEPTH are dropped unless one is spent now
  assign credit_take = i_out_credit &&
                       ((out_credit_q != credit_t'(BUF_DEPTH)) || rd_launch);

  always_comb begin
    case ({i_push, rd_launch})
      2'b10:   level_d = level_q + credit_t'(1);
      2'b01:   level_d = level_q - credit_t'(1);
      default: level_d = level_q;
    endcase
  end

  always_comb begin
    case ({credit_take, rd_launch})
      2'b10:   out_credit_d = out_credit_q + credit_t'(1);
      2'b01:   out_credit_d = out_credit_q - credit_t'(1);
      default: out_credit_d = out_credit_q;
    endcase
  end

  // ========================================
  // Control state
  // ========================================

  always_ff @(posedge i_periph_clk or negedge i_periph_rst_n) begin
    if (!i_periph_rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      level_q      <= '0;
      out_credit_q <= '0;
      valid_q      <= 1'b0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + buf_addr_t'(1);
      end
      if (rd_launch) begin
        rd_ptr <= rd_ptr + buf_addr_t'(1);
      end
      level_q      <= level_d;
      out_credit_q <= out_credit_d;
      // Read data is ready one cycle after launch
      valid_q      <= rd_launch;
    end
  end

  periph_buffer_ram #(
    .WIDTH(WIDTH)
  ) u_buffer_ram (
    .i_periph_clk  (i_periph_clk),
    .i_periph_rst_n(i_periph_rst_n),
    .i_wr_en       (i_push),
    .i_wr_addr     (wr_ptr),
    .i_wr_data     (i_push_data),
    .i_rd_en       (rd_launch),
    .i_rd_addr     (rd_ptr),
    .o_rd_data     (rd_data)
  );

  // Entry leaves, so its slot goes back to the writer
  assign o_out_valid   = valid_q;
  assign o_push_credit = valid_q;
  assign o_out_data    = rd_data;
  assign o_level       = level_q;

endmodule

`default_nettype wire

//--- hdl/irq_aggregator.sv
// Peripheral interrupt aggregation
// Reduces flag vectors to one line per block, all behind one register stage
`timescale 1ns/1ns
`default_nettype none

module irq_aggregator (
  input  wire                        i_periph_clk,
  input  wire                        i_periph_rst_n,
  input  wire logic                  i_gpio_irq,
  input  wire soc_periph_pkg::i2c_irq_t   i_i2c0_irq,
  input  wire soc_periph_pkg::i2c_irq_t   i_i2c1_irq,
  input  wire soc_periph_pkg::spi_irq_t   i_spi_irq,
  input  wire soc_periph_pkg::timer_irq_t i_timer_irq,
  input  wire logic                  i_emmc_irq,
  input  wire soc_periph_pkg::credit_t    i_rx_level,
  output logic                       o_gpio_irq,
  output logic                       o_uart_irq,
  output logic                       o_i2c0_irq,
  output logic                       o_i2c1_irq,
  output logic                       o_spi_irq,
  output logic                       o_timer_irq,
  output logic                       o_emmc_irq
);

  logic uart_irq;
  logic i2c0_irq;
  logic i2c1_irq;
  logic spi_irq;
  logic timer_irq;

  // UART raises while the receive buffer holds entries
  assign uart_irq  = (i_rx_level != '0);

  // Any flag of a block raises its line
  assign i2c0_irq  = |i_i2c0_irq;
  assign i2c1_irq  = |i_i2c1_irq;
  assign spi_irq   = |i_spi_irq;
  assign timer_irq = |i_timer_irq;

  // ========================================
  // Output register stage
  // ========================================

  always_ff @(posedge i_periph_clk or negedge i_periph_rst_n) begin
    if (!i_periph_rst_n) begin
      o_gpio_irq  <= 1'b0;
      o_uart_irq  <= 1'b0;
      o_i2c0_irq  <= 1'b0;
      o_i2c1_irq  <= 1'b0;
      o_spi_irq   <= 1'b0;
      o_timer_irq <= 1'b0;
      o_emmc_irq  <= 1'b0;
    end else begin
      // GPIO and eMMC pass through
      o_gpio_irq  <= i_gpio_irq;
      o_uart_irq  <= uart_irq;
      o_i2c0_irq  <= i2c0_irq;
      o_i2c1_irq  <= i2c1_irq;
      o_spi_irq   <= spi_irq;
      o_timer_irq <= timer_irq;
      o_emmc_irq  <= i_emmc_irq;
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_periph.sv
// SoC peripheral block, buffered part
// UART transmit and receive buffers plus registered interrupt aggregation
`timescale 1ns/1ns
`default_nettype none

module soc_periph (
  input  wire                             i_periph_clk,
  input  wire                             i_periph_rst_n,
  // Host transmit side
  input  wire logic                       i_tx_push,
  input  wire soc_periph_pkg::uart_byte_t i_tx_data,
  output logic                            o_tx_push_credit,
  // Serial engine transmit side
  input  wire logic                       i_tx_out_credit,
  output logic                            o_tx_valid,
  output soc_periph_pkg::uart_byte_t      o_tx_data,
  // Serial engine receive side
  input  wire logic                       i_rx_push,
  input  wire soc_periph_pkg::uart_rx_entry_t i_rx_data,
  output logic                            o_rx_push_credit,
  // Host receive side
  input  wire logic                       i_rx_out_credit,
  output logic                            o_rx_valid,
  output soc_periph_pkg::uart_rx_entry_t  o_rx_data,
  // Interrupt sources
  input  wire logic                       i_gpio_irq,
  input  wire soc_periph_pkg::i2c_irq_t   i_i2c0_irq,
  input  wire soc_periph_pkg::i2c_irq_t   i_i2c1_irq,
  input  wire soc_periph_pkg::spi_irq_t   i_spi_irq,
  input  wire soc_periph_pkg::timer_irq_t i_timer_irq,
  input  wire logic                       i_emmc_irq,
  // Interrupt outputs
  output logic                            o_gpio_irq,
  output logic                            o_uart_irq,
  output logic                            o_i2c0_irq,
  output logic                            o_i2c1_irq,
  output logic                            o_spi_irq,
  output logic                            o_timer_irq,
  output logic                            o_emmc_irq
);
  import soc_periph_pkg::*;

  credit_t rx_level;

  // ========================================
  // UART buffers
  // ========================================

  credit_fifo #(
    .WIDTH($bits(uart_byte_t))
  ) tx_fifo (
    .i_periph_clk  (i_periph_clk),
    .i_periph_rst_n(i_periph_rst_n),
    .i_push        (i_tx_push),
    .i_push_data   (i_tx_data),
    .o_push_credit (o_tx_push_credit),
    .i_out_credit  (i_tx_out_credit),
    .o_out_valid   (o_tx_valid),
    .o_out_data    (o_tx_data),
    .o_level       ()
  );

  // Receive level drives the UART interrupt
  credit_fifo #(
    .WIDTH($bits(uart_rx_entry_t))
  ) rx_fifo (
    .i_periph_clk  (i_periph_clk),
    .i_periph_rst_n(i_periph_rst_n),
    .i_push        (i_rx_push),
    .i_push_data   (i_rx_data),
    .o_push_credit (o_rx_push_credit),
    .i_out_credit  (i_rx_out_credit),
    .o_out_valid   (o_rx_valid),
    .o_out_data    (o_rx_data),
    .o_level       (rx_level)
  );

  // ========================================
  // Interrupts
  // ========================================

  irq_aggregator irq_agg (
    .i_periph_clk  (i_periph_clk),
    .i_periph_rst_n(i_periph_rst_n),
    .i_gpio_irq    (i_gpio_irq),
    .i_i2c0_irq    (i_i2c0_irq),
    .i_i2c1_irq    (i_i2c1_irq),
    .i_spi_irq     (i_spi_irq),
    .i_timer_irq   (i_timer_irq),
    .i_emmc_irq    (i_emmc_irq),
    .i_rx_level    (rx_level),
    .o_gpio_irq    (o_gpio_irq),
    .o_uart_irq    (o_uart_irq),
    .o_i2c0_irq    (o_i2c0_irq),
    .o_i2c1_irq    (o_i2c1_irq),
    .o_spi_irq     (o_spi_irq),
    .o_timer_irq   (o_timer_irq),
    .o_emmc_irq    (o_emmc_irq)
  );

endmodule

`default_nettype wire

//--- testbench/soc_periph_assertions.sv
// Credit and reset checks bound into each UART buffer
`timescale 1ns/1ns
`default_nettype none

module soc_periph_assertions (
  input wire logic                    i_periph_clk,
  input wire logic                    i_periph_rst_n,
  input wire logic                    i_push,
  input wire logic                    i_out_valid,
  input wire logic                    i_push_credit,
  input wire soc_periph_pkg::credit_t i_level
);
  import soc_periph_pkg::*;

  // Held entries plus the one on the output are still owed to the writer
  property p_push_needs_credit;
    @(posedge i_periph_clk) disable iff (!i_periph_rst_n)
      i_push |-> (int'(i_level) + int'(i_out_valid)) < int'(BUF_DEPTH);
  endproperty

  // A launch takes one entry out of the occupancy the cycle before valid
  property p_valid_after_launch;
    @(posedge i_periph_clk) disable iff (!i_periph_rst_n)
      i_out_valid |-> $past(i_level != '0) &&
        (int'(i_level) == int'($past(i_level)) + int'($past(i_push)) - 1);
  endproperty

  property p_reset_outputs_low;
    @(posedge i_periph_clk)
      (!i_periph_rst_n && $past(!i_periph_rst_n)) |->
        (!i_out_valid && !i_push_credit && i_level == '0);
  endproperty

  a_push_needs_credit: assert property (p_push_needs_credit)
    else $error("push while the writer held no credit");
  a_valid_after_launch: assert property (p_valid_after_launch)
    else $error("output valid without a read launch in the previous cycle");
  a_reset_outputs_low: assert property (p_reset_outputs_low)
    else $error("buffer outputs not low during reset");

endmodule

bind credit_fifo soc_periph_assertions u_credit_checks (
  .i_periph_clk  (i_periph_clk),
  .i_periph_rst_n(i_periph_rst_n),
  .i_push        (i_push),
  .i_out_valid   (o_out_valid),
  .i_push_credit (o_push_credit),
  .i_level       (level_q)
);

`default_nettype wire

//--- testbench/tb_soc_periph.sv
// Testbench for the buffered SoC peripheral block
// Vector-driven buffer and interrupt tests against a queue model
`timescale 1ns/1ns
`default_nettype none

module tb_soc_periph;
  import soc_periph_pkg::*;

  localparam int NUM_VEC     = 22;
  localparam int VEC_FIELDS  = 5;
  localparam int CYC_PER_VEC = 40;

  logic           i_periph_clk;
  logic           i_periph_rst_n;
  logic           i_tx_push, i_tx_out_credit, i_rx_push, i_rx_out_credit;
  uart_byte_t     i_tx_data, o_tx_data;
  uart_rx_entry_t i_rx_data, o_rx_data;
  logic           o_tx_push_credit, o_tx_valid, o_rx_push_credit, o_rx_valid;
  logic           i_gpio_irq, i_emmc_irq;
  i2c_irq_t       i_i2c0_irq, i_i2c1_irq;
  spi_irq_t       i_spi_irq;
  timer_irq_t     i_timer_irq;
  logic           o_gpio_irq, o_uart_irq, o_i2c0_irq, o_i2c1_irq;
  logic           o_spi_irq, o_timer_irq, o_emmc_irq;

  logic [31:0]    vec_mem [NUM_VEC*VEC_FIELDS];
  uart_byte_t     exp_tx [$];
  uart_rx_entry_t exp_rx [$];
  logic [31:0]    lcg_state;
  int             tx_spent, tx_returned, tx_valid_cnt;
  int             rx_spent, rx_returned, rx_valid_cnt;
  int             value_errs, other_errs;

  soc_periph dut0 (.*);

  initial begin
    i_periph_clk = 1'b0;
    forever #4 i_periph_clk = ~i_periph_clk;
  end

  // ========================================
  // Compare tasks and helpers
  // ========================================

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_rx_entry(input string name, input uart_rx_entry_t exp,
                                input uart_rx_entry_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
    end
  endtask

  // Bits 6..0 are gpio, uart, i2c0, i2c1, spi, timer, emmc
  task automatic check_irq_outputs(input logic [6:0] exp);
    check_irq("o_gpio_irq", exp[6], o_gpio_irq);
    check_irq("o_uart_irq", exp[5], o_uart_irq);
    check_irq("o_i2c0_irq", exp[4], o_i2c0_irq);
    check_irq("o_i2c1_irq", exp[3], o_i2c1_irq);
    check_irq("o_spi_irq", exp[2], o_spi_irq);
    check_irq("o_timer_irq", exp[1], o_timer_irq);
    check_irq("o_emmc_irq", exp[0], o_emmc_irq);
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge i_periph_clk);
      i_tx_push       <= 1'b0;
      i_rx_push       <= 1'b0;
      i_tx_out_credit <= 1'b0;
      i_rx_out_credit <= 1'b0;
    end
  endtask

  // Writer model holds off until a credit is back
  task automatic push_tx(input uart_byte_t data, input logic grant);
    @(posedge i_periph_clk);
    while (int'(BUF_DEPTH) - tx_spent + tx_returned <= 0) begin
      i_tx_push       <= 1'b0;
      i_tx_out_credit <= 1'b0;
      @(posedge i_periph_clk);
    end
    i_tx_push       <= 1'b1;
    i_tx_data       <= data;
    i_tx_out_credit <= grant;
    tx_spent++;
    exp_tx.push_back(data);
  endtask

  task automatic push_rx(input uart_rx_entry_t data);
    @(posedge i_periph_clk);
    while (int'(BUF_DEPTH) - rx_spent + rx_returned <= 0) begin
      i_rx_push <= 1'b0;
      @(posedge i_periph_clk);
    end
    i_rx_push <= 1'b1;
    i_rx_data <= data;
    rx_spent++;
    exp_rx.push_back(data);
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while ((exp_tx.size() + exp_rx.size() != 0) && n < limit) begin
      @(posedge i_periph_clk);
      n++;
    end
    if (exp_tx.size() + exp_rx.size() != 0) begin
      other_errs++;
      $display("Buffers kept %0d tx and %0d rx entries that never came out",
               exp_tx.size(), exp_rx.size());
      exp_tx.delete();
      exp_rx.delete();
    end
    if (tx_returned != tx_valid_cnt || rx_returned != rx_valid_cnt) begin
      other_errs++;
      $display("Push credit pulses do not match the number of entries read");
    end
  endtask

  // ========================================
  // Test sequences
  // ========================================

  task automatic run_tx_backpressure(input int count, input int first, input int step);
    int valid_before;
    valid_before = tx_valid_cnt;
    for (int i = 0; i < count; i++) push_tx(uart_byte_t'(first + i * step), 1'b0);
    idle_cycles(8);
    if (tx_valid_cnt != valid_before) begin
      other_errs++;
      $display("Transmit buffer sent data while holding no reader credit");
    end
    if (count == int'(BUF_DEPTH) && tx_spent != tx_returned + int'(BUF_DEPTH)) begin
      other_errs++;
      $display("Writer still holds credits with the transmit buffer full");
    end
    for (int i = 0; i < count; i++) begin
      idle_cycles(int'((lcg_next() >> 16) % 4));
      @(posedge i_periph_clk);
      i_tx_out_credit <= 1'b1;
    end
    idle_cycles(1);
    wait_drained(16);
  endtask

  task automatic run_rx_burst(input int count, input int first, input int step,
                              input logic irq_held);
    for (int i = 0; i < count; i++) push_rx(uart_rx_entry_t'(first + i * step));
    idle_cycles(4);
    @(negedge i_periph_clk);
    check_irq("o_uart_irq", irq_held, o_uart_irq);
    repeat (count) begin
      @(posedge i_periph_clk);
      i_rx_out_credit <= 1'b1;
    end
    idle_cycles(1);
    wait_drained(16);
    idle_cycles(4);
    @(negedge i_periph_clk);
    check_irq("o_uart_irq", 1'b0, o_uart_irq);
  endtask

  // misc holds gpio, emmc, timer[1:0], spi[5:0] from msb down
  task automatic run_irq_pattern(input logic [31:0] i2c0, input logic [31:0] i2c1,
                                 input logic [31:0] misc, input logic [6:0] exp);
    @(posedge i_periph_clk);
    i_i2c0_irq  <= i2c_irq_t'(i2c0);
    i_i2c1_irq  <= i2c_irq_t'(i2c1);
    i_gpio_irq  <= misc[9];
    i_emmc_irq  <= misc[8];
    i_timer_irq <= misc[7:6];
    i_spi_irq   <= misc[5:0];
    @(posedge i_periph_clk);
    @(negedge i_periph_clk);
    check_irq_outputs(exp);
    @(posedge i_periph_clk);
    i_i2c0_irq  <= '0;
    i_i2c1_irq  <= '0;
    i_gpio_irq  <= 1'b0;
    i_emmc_irq  <= 1'b0;
    i_timer_irq <= '0;
    i_spi_irq   <= '0;
  endtask

  // Entries leave in push order, checked mid-cycle
  always @(negedge i_periph_clk) begin
    if (i_periph_rst_n) begin
      if (o_tx_push_credit) tx_returned++;
      if (o_rx_push_credit) rx_returned++;
      if (o_tx_valid) begin
        tx_valid_cnt++;
        if (exp_tx.size() == 0) begin
          other_errs++;
          $display("Transmit buffer produced a byte that was never pushed");
        end else begin
          check_byte("o_tx_data", exp_tx.pop_front(), o_tx_data);
        end
      end
      if (o_rx_valid) begin
        rx_valid_cnt++;
        if (exp_rx.size() == 0) begin
          other_errs++;
          $display("Receive buffer produced an entry that was never pushed");
        end else begin
          check_rx_entry("o_rx_data", exp_rx.pop_front(), o_rx_data);
        end
      end
    end
  end

  initial begin : main
    logic [31:0] f [VEC_FIELDS];
    i_periph_rst_n  = 1'b0;
    i_tx_push       = 1'b0;
    i_tx_data       = '0;
    i_tx_out_credit = 1'b0;
    i_rx_push       = 1'b0;
    i_rx_data       = '0;
    i_rx_out_credit = 1'b0;
    i_gpio_irq      = 1'b0;
    i_emmc_irq      = 1'b0;
    i_i2c0_irq      = '0;
    i_i2c1_irq      = '0;
    i_spi_irq       = '0;
    i_timer_irq     = '0;
    {tx_spent, tx_returned, tx_valid_cnt} = '0;
    {rx_spent, rx_returned, rx_valid_cnt} = '0;
    value_errs = 0;
    other_errs = 0;
    lcg_state  = 32'hd20a_7ed6;
    $readmemh("testbench/soc_periph_vectors.txt", vec_mem);
    repeat (4) @(posedge i_periph_clk);
    i_periph_rst_n <= 1'b1;
    idle_cycles(4);
    @(negedge i_periph_clk);
    check_irq_outputs(7'h00);
    check_irq("o_tx_valid", 1'b0, o_tx_valid);
    check_irq("o_rx_valid", 1'b0, o_rx_valid);
    if (tx_returned + rx_returned != 0) begin
      other_errs++;
      $display("Push credit returned before any entry was read");
    end
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int k = 0; k < VEC_FIELDS; k++) f[k] = vec_mem[v * VEC_FIELDS + k];
      if (f[0] == 32'd0) break;
      case (f[0])
        32'd1: begin
          for (int i = 0; i < int'(f[1]); i++) push_tx(uart_byte_t'(f[2] + i * f[3]), 1'b1);
          idle_cycles(1);
          wait_drained(16);
        end
        32'd2: run_rx_burst(int'(f[1]), int'(f[2]), int'(f[3]), f[4][0]);
        32'd3: run_tx_backpressure(int'(f[1]), int'(f[2]), int'(f[3]));
        32'd4: run_irq_pattern(f[1], f[2], f[3], f[4][6:0]);
        default: begin
          other_errs++;
          $display("Vector line %0d holds an unknown operation %0d", v, f[0]);
        end
      endcase
    end
    idle_cycles(4);
    $display("Error counts: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NUM_VEC * CYC_PER_VEC + 16) @(posedge i_periph_clk);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Error counts: %0d value errors, %0d other errors", value_errs, other_errs);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/soc_periph_vectors.txt
// op a b c d, hex; op 1 tx burst, 2 rx burst, 3 tx back-pressure, 4 irq pattern, 0 ends
// burst a=count b=first c=step d=uart irq held; irq a=i2c0 b=i2c1 c=misc d=expected outputs
4 00000 00000 000 00
4 00001 00000 000 10
4 10000 00000 000 10
4 00000 08000 000 08
4 00000 00000 020 04
4 00000 00000 040 02
4 00000 00000 080 02
4 00000 00000 100 01
4 00000 00000 200 40
4 1ffff 1ffff 3ff 5f
1 01 a5 00 00
1 08 00 11 00
1 10 3c 07 00
2 01 3ff 000 01
2 04 100 101 01
2 10 2a5 05b 01
3 10 80 01 00
1 05 f0 13 00
3 10 c7 35 00
2 08 055 0c3 01
4 0aaaa 15555 155 1f
0 0 0 0 0

//--- all.f
hdl/soc_periph_pkg.sv
hdl/periph_buffer_ram.sv
hdl/credit_fifo.sv
hdl/irq_aggregator.sv
hdl/soc_periph.sv
testbench/soc_periph_assertions.sv
testbench/tb_soc_periph.sv
